// File: common/decodePkg.sv
package decodePkg;

	// Machine widths are fixed by the ISA
	localparam int wordWidth = 16; // Data and instruction word
	localparam int regAddrWidth = 3; // Register specifier
	localparam int numRegs = 8;
	localparam int opcodeWidth = 5; // Top field of every instruction word
	localparam logic [regAddrWidth-1:0] linkReg = 3'd7; // JAL and JALR write the return address here

	// Supported opcodes, anything else is treated as a NOP
	typedef enum logic [opcodeWidth-1:0] {
		NOP = 5'b00001,
		J = 5'b00100,
		JR = 5'b00101,
		JAL = 5'b00110,
		JALR = 5'b00111,
		ADDI = 5'b01000,
		SUBI = 5'b01001,
		XORI = 5'b01010,
		ANDNI = 5'b01011,
		BEQZ = 5'b01100,
		BNEZ = 5'b01101,
		ST = 5'b10000,
		LD = 5'b10001,
		SLBI = 5'b10010,
		STU = 5'b10011,
		LBI = 5'b11000,
		ALU = 5'b11011 // R format group, operation picked by the extension bits
	} opcode_e;

	// Extension bits in instr[1:0] of the R format group
	typedef enum logic [1:0] {
		fnAdd = 2'b00,
		fnSub = 2'b01,
		fnXor = 2'b10,
		fnAndn = 2'b11
	} aluFunct_e;

	typedef enum logic [1:0] {
		formJ = 2'b00, // Opcode and an 11-bit displacement
		formI1 = 2'b01, // Opcode, Rs, Rd and a 5-bit immediate
		formI2 = 2'b10, // Opcode, Rs and an 8-bit immediate
		formR = 2'b11 // Opcode, Rs, Rt, Rd and the extension bits
	} format_e;

	typedef enum logic [2:0] {
		opAdd = 3'd0,
		opSub = 3'd1,
		opXor = 3'd2,
		opAndn = 3'd3,
		opPass = 3'd4, // Hands the operand or immediate straight through
		opShiftLoad = 3'd5 // SLBI shifts Rs left by eight and ors in the immediate
	} aluOp_e;

	typedef enum logic [2:0] {
		immNone = 3'd0,
		immS5 = 3'd1,
		immZ5 = 3'd2,
		immS8 = 3'd3,
		immZ8 = 3'd4,
		immS11 = 3'd5
	} immKind_e;

	// Control flags for the later stages
	typedef struct packed {
		aluOp_e aluOp;
		logic memRead;
		logic memWrite;
		logic isBranch;
		logic isJump;
		logic linkWrite; // Result is the incremented PC
	} ctrl_t;

	typedef struct packed {
		logic [regAddrWidth-1:0] rdA;
		logic [regAddrWidth-1:0] rdB;
		logic [regAddrWidth-1:0] wr;
		logic wrEn;
	} regSpec_t;

	// Everything execute needs for one instruction
	typedef struct packed {
		ctrl_t ctrl;
		regSpec_t spec;
		logic [wordWidth-1:0] opA;
		logic [wordWidth-1:0] opB;
		logic [wordWidth-1:0] imm;
		logic [wordWidth-1:0] incrPc;
		format_e fmt;
	} decoded_t;

	typedef struct packed {
		logic en;
		logic [regAddrWidth-1:0] addr;
		logic [wordWidth-1:0] data;
	} writeback_t;

endpackage

// File: hw/decode/controlDecoder.sv
`timescale 1ns/100ps

module controlDecoder (
	input logic [decodePkg::wordWidth-1:0] instr,
	output decodePkg::format_e fmt,
	output decodePkg::ctrl_t ctrl,
	output decodePkg::immKind_e immKind
);

	decodePkg::opcode_e opcode;
	decodePkg::aluFunct_e funct; // Only meaningful for the R group

	// Opcode sits in the top five bits for every format
	assign opcode = decodePkg::opcode_e'(
		instr[decodePkg::wordWidth-1 -: decodePkg::opcodeWidth]);
	assign funct = decodePkg::aluFunct_e'(instr[1:0]);

	always_comb begin
		// Defaults describe a NOP, so an unknown opcode does nothing
		fmt = decodePkg::formJ;
		immKind = decodePkg::immNone;
		ctrl = '0;
		ctrl.aluOp = decodePkg::opPass;

		case (opcode)
			// I format 1 arithmetic uses signed adds and unsigned logic ops
			decodePkg::ADDI: begin
				fmt = decodePkg::formI1;
				immKind = decodePkg::immS5;
				ctrl.aluOp = decodePkg::opAdd;
			end
			decodePkg::SUBI: begin
				fmt = decodePkg::formI1;
				immKind = decodePkg::immS5;
				ctrl.aluOp = decodePkg::opSub; // Immediate minus Rs
			end
			decodePkg::XORI: begin
				fmt = decodePkg::formI1;
				immKind = decodePkg::immZ5;
				ctrl.aluOp = decodePkg::opXor;
			end
			decodePkg::ANDNI: begin
				fmt = decodePkg::formI1;
				immKind = decodePkg::immZ5;
				ctrl.aluOp = decodePkg::opAndn;
			end
			// Memory ops compute Rs plus a signed offset
			decodePkg::ST, decodePkg::STU: begin
				fmt = decodePkg::formI1;
				immKind = decodePkg::immS5;
				ctrl.aluOp = decodePkg::opAdd;
				ctrl.memWrite = 1'b1;
			end
			decodePkg::LD: begin
				fmt = decodePkg::formI1;
				immKind = decodePkg::immS5;
				ctrl.aluOp = decodePkg::opAdd;
				ctrl.memRead = 1'b1;
			end
			decodePkg::LBI: begin
				fmt = decodePkg::formI2;
				immKind = decodePkg::immS8; // Rs gets the immediate as is
			end
			decodePkg::SLBI: begin
				fmt = decodePkg::formI2;
				immKind = decodePkg::immZ8;
				ctrl.aluOp = decodePkg::opShiftLoad;
			end
			decodePkg::BEQZ, decodePkg::BNEZ: begin
				fmt = decodePkg::formI2;
				immKind = decodePkg::immS8; // PC relative displacement
				ctrl.isBranch = 1'b1; // ALU passes Rs for the zero test
			end
			// Register jumps target Rs plus a signed offset
			decodePkg::JR: begin
				fmt = decodePkg::formI2;
				immKind = decodePkg::immS8;
				ctrl.aluOp = decodePkg::opAdd;
				ctrl.isJump = 1'b1;
			end
			decodePkg::JALR: begin
				fmt = decodePkg::formI2;
				immKind = decodePkg::immS8;
				ctrl.aluOp = decodePkg::opAdd;
				ctrl.isJump = 1'b1;
				ctrl.linkWrite = 1'b1;
			end
			// PC relative jumps with the long displacement
			decodePkg::J: begin
				immKind = decodePkg::immS11;
				ctrl.aluOp = decodePkg::opAdd;
				ctrl.isJump = 1'b1;
			end
			decodePkg::JAL: begin
				immKind = decodePkg::immS11;
				ctrl.aluOp = decodePkg::opAdd;
				ctrl.isJump = 1'b1;
				ctrl.linkWrite = 1'b1;
			end
			decodePkg::ALU: begin
				fmt = decodePkg::formR;
				case (funct)
					decodePkg::fnAdd: ctrl.aluOp = decodePkg::opAdd;
					decodePkg::fnSub: ctrl.aluOp = decodePkg::opSub;
					decodePkg::fnXor: ctrl.aluOp = decodePkg::opXor;
					decodePkg::fnAndn: ctrl.aluOp = decodePkg::opAndn;
				endcase
			end
			default: begin
				// NOP and every unlisted code keep the defaults
			end
		endcase
	end

endmodule

// File: hw/decode/immGen.sv
`timescale 1ns/100ps

module immGen (
	input logic [decodePkg::wordWidth-1:0] instr,
	input decodePkg::immKind_e immKind,
	output logic [decodePkg::wordWidth-1:0] imm
);

	localparam int w = decodePkg::wordWidth;

	logic [4:0] field5; // I format 1
	logic [7:0] field8; // I format 2
	logic [10:0] field11; // J format displacement

	// All three fields start at bit 0
	assign field5 = instr[4:0];
	assign field8 = instr[7:0];
	assign field11 = instr[10:0];

	always_comb begin
		case (immKind)
			decodePkg::immS5: begin
				imm = {{(w - 5){field5[4]}}, field5};
			end
			decodePkg::immZ5: begin
				imm = {{(w - 5){1'b0}}, field5};
			end
			decodePkg::immS8: begin
				imm = {{(w - 8){field8[7]}}, field8};
			end
			decodePkg::immZ8: begin
				imm = {{(w - 8){1'b0}}, field8};
			end
			decodePkg::immS11: begin
				imm = {{(w - 11){field11[10]}}, field11};
			end
			default: begin
				imm = '0; // R format and NOP carry no immediate
			end
		endcase
	end

endmodule

// File: hw/decode/regSpecDecoder.sv
`timescale 1ns/100ps

module regSpecDecoder (
	input decodePkg::format_e fmt,
	input logic [decodePkg::wordWidth-1:0] instr,
	output decodePkg::regSpec_t spec
);

	decodePkg::opcode_e opcode;
	logic [decodePkg::regAddrWidth-1:0] rs; // Same position in every format that has one
	logic [decodePkg::regAddrWidth-1:0] fieldB; // Rd of I format 1, Rt of R format
	logic [decodePkg::regAddrWidth-1:0] fieldC; // Rd of R format

	assign opcode = decodePkg::opcode_e'(
		instr[decodePkg::wordWidth-1 -: decodePkg::opcodeWidth]);
	assign rs = instr[10:8];
	assign fieldB = instr[7:5];
	assign fieldC = instr[4:2];

	always_comb begin
		spec = '0; // Register 0 and no write unless a rule below says otherwise

		case (fmt)
			decodePkg::formJ: begin
				// Nothing is read, only JAL saves a return address
				if (opcode == decodePkg::JAL) begin
					spec.wr = decodePkg::linkReg;
					spec.wrEn = 1'b1;
				end
			end
			decodePkg::formI1: begin
				spec.rdA = rs;
				// Stores send Rd to memory as the data
				if (opcode == decodePkg::ST || opcode == decodePkg::STU) begin
					spec.rdB = fieldB;
				end
				spec.wr = (opcode == decodePkg::STU) ? rs : fieldB; // STU updates the base
				spec.wrEn = (opcode != decodePkg::ST);
			end
			decodePkg::formI2: begin
				spec.rdA = rs;
				if (opcode == decodePkg::JALR) begin
					spec.wr = decodePkg::linkReg;
					spec.wrEn = 1'b1;
				end else if (opcode == decodePkg::LBI || opcode == decodePkg::SLBI) begin
					spec.wr = rs; // Immediate loads overwrite their own source
					spec.wrEn = 1'b1;
				end
				// Branches and JR leave the write disabled
			end
			decodePkg::formR: begin
				spec.rdA = rs;
				spec.rdB = fieldB;
				spec.wr = fieldC;
				spec.wrEn = 1'b1;
			end
		endcase
	end

endmodule

// File: hw/decodeStage.sv
`timescale 1ns/100ps

module decodeStage (
	input logic clk,
	input logic rstN,
	input logic inValid,
	output logic inReady,
	input logic [decodePkg::wordWidth-1:0] instr,
	input logic [decodePkg::wordWidth-1:0] incrPc,
	input decodePkg::writeback_t wb,
	output logic outValid,
	input logic outReady,
	output decodePkg::decoded_t outBundle
);

	decodePkg::format_e fmt;
	decodePkg::ctrl_t ctrl;
	decodePkg::immKind_e immKind;
	decodePkg::regSpec_t spec;
	logic [decodePkg::wordWidth-1:0] opA;
	logic [decodePkg::wordWidth-1:0] opB;
	logic [decodePkg::wordWidth-1:0] imm;
	decodePkg::decoded_t nextBundle; // Decode result for the word on instr
	logic accept;

	controlDecoder ctrlDec (
		.instr(instr),
		.fmt(fmt),
		.ctrl(ctrl),
		.immKind(immKind)
	);

	// Needs the format from the control decoder
	regSpecDecoder specDec (
		.fmt(fmt),
		.instr(instr),
		.spec(spec)
	);

	regFile rf (
		.clk(clk),
		.rstN(rstN),
		.rdA(spec.rdA),
		.rdB(spec.rdB),
		.wb(wb),
		.opA(opA),
		.opB(opB)
	);

	immGen immUnit (
		.instr(instr),
		.immKind(immKind),
		.imm(imm)
	);

	// Room when the register is empty or being drained this cycle
	assign inReady = !outValid || outReady;
	assign accept = inValid && inReady;

	always_comb begin
		nextBundle.ctrl = ctrl;
		nextBundle.spec = spec;
		nextBundle.opA = opA;
		nextBundle.opB = opB;
		nextBundle.imm = imm;
		nextBundle.incrPc = incrPc; // Carried along for links and PC relative targets
		nextBundle.fmt = fmt;
	end

	// Valid follows the input whenever the register may change
	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			outValid <= 1'b0;
		end else if (inReady) begin
			outValid <= inValid;
		end
	end

	// Payload only loads on acceptance, so a stall keeps the latched operands
	always_ff @(posedge clk) begin
		if (accept) begin
			outBundle <= nextBundle;
		end
	end

endmodule

// File: hw/regFile.sv
`timescale 1ns/100ps

module regFile (
	input logic clk,
	input logic rstN,
	input logic [decodePkg::regAddrWidth-1:0] rdA,
	input logic [decodePkg::regAddrWidth-1:0] rdB,
	input decodePkg::writeback_t wb,
	output logic [decodePkg::wordWidth-1:0] opA,
	output logic [decodePkg::wordWidth-1:0] opB
);

	logic [decodePkg::wordWidth-1:0] regs [decodePkg::numRegs];
	logic hitA; // Writeback targets the register read on port A this cycle
	logic hitB;

	// Single write port, every register starts at zero
	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			for (int i = 0; i < decodePkg::numRegs; i++) begin
				regs[i] <= '0;
			end
		end else if (wb.en) begin
			regs[wb.addr] <= wb.data;
		end
	end

	assign hitA = wb.en && (wb.addr == rdA);
	assign hitB = wb.en && (wb.addr == rdB);

	// Forward the writeback so a same-cycle read sees the new value
	assign opA = hitA ? wb.data : regs[rdA];
	assign opB = hitB ? wb.data : regs[rdB];

endmodule

// File: run.sh
#!/bin/sh
# Build and run the decode stage testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f src.f --top-module decodeStageTb \
	--Mdir obj_dir -o simv
status=$?
if [ $status -ne 0 ]; then
	echo "Verilator build failed"
	exit $status
fi

./obj_dir/simv
status=$?
if [ $status -ne 0 ]; then
	echo "Simulation failed"
	exit $status
fi

echo "Simulation finished"
exit 0

// File: src.f
common/decodePkg.sv
hw/decode/controlDecoder.sv
hw/decode/regSpecDecoder.sv
hw/decode/immGen.sv
hw/regFile.sv
hw/decodeStage.sv
verification/clockGen.sv
verification/decodeStageTb.sv

// File: verification/clockGen.sv
`timescale 1ns/100ps

module clockGen (
	output logic clk,
	output logic rstN
);

	localparam int resetCycles = 10;

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk; // 10 ns period
	end

	// Reset leaves on a rising edge like every other driven input
	initial begin
		rstN = 1'b0;
		repeat (resetCycles) @(posedge clk);
		rstN <= 1'b1;
	end

endmodule

// File: verification/decodeStageTb.sv
`timescale 1ns/100ps

module decodeStageTb;

	// One table entry holds the stimulus first and the expected decode after it
	typedef struct packed {
		logic [15:0] instr;
		logic [15:0] incrPc;
		decodePkg::writeback_t wb; // Writeback presented together with the instruction
		logic [3:0] hold; // Cycles outReady stays low after this row leaves
		decodePkg::format_e fmt;
		decodePkg::ctrl_t ctrl;
		decodePkg::regSpec_t spec;
		logic [15:0] imm;
	} row_t;

	logic clk;
	logic rstN;
	logic inValid;
	logic inReady;
	logic [15:0] instr;
	logic [15:0] incrPc;
	decodePkg::writeback_t wb;
	logic outValid;
	logic outReady;
	decodePkg::decoded_t outBundle;

	row_t rows[$];
	decodePkg::decoded_t expQ[$]; // Bundles accepted but not yet seen at the output
	int holdQ[$];
	logic [15:0] shadow [8]; // What the register file should hold
	logic [31:0] lfsr = 32'hb554f778;
	int holdLeft = 0;
	int checked = 0;
	bit heldValid = 0;
	decodePkg::decoded_t heldBundle;

	clockGen clkGen (.clk(clk), .rstN(rstN));

	decodeStage uut (
		.clk(clk),
		.rstN(rstN),
		.inValid(inValid),
		.inReady(inReady),
		.instr(instr),
		.incrPc(incrPc),
		.wb(wb),
		.outValid(outValid),
		.outReady(outReady),
		.outBundle(outBundle)
	);

	// Galois LFSR stepped once for every bit handed out
	function automatic logic [31:0] takeBits(input int n);
		logic [31:0] bits;
		logic b;
		bits = '0;
		for (int i = 0; i < n; i++) begin
			b = lfsr[0];
			lfsr = lfsr >> 1;
			if (b) lfsr = lfsr ^ 32'ha3000000;
			bits = {bits[30:0], b};
		end
		return bits;
	endfunction

	task automatic abortRun(input string why);
		$display("%s", why);
		$display("** FAIL **");
		$fatal(1);
	endtask

	task automatic checkWord(input logic [15:0] got, input logic [15:0] exp, input string what);
		if (got !== exp)
			abortRun($sformatf("error %0d ns: %s is %h, expected %h", $time, what, got, exp));
	endtask

	task automatic checkFmt(input decodePkg::format_e got, input decodePkg::format_e exp,
		input string what);
		if (got !== exp)
			abortRun($sformatf("error %0d ns: %s format is %s, expected %s", $time, what,
				got.name(), exp.name()));
	endtask

	task automatic checkCtrl(input decodePkg::ctrl_t got, input decodePkg::ctrl_t exp,
		input string what);
		if (got !== exp)
			abortRun($sformatf("error %0d ns: %s ctrl is %h, expected %h", $time, what, got, exp));
	endtask

	// The write specifier means nothing while the write is disabled
	task automatic checkSpec(input decodePkg::regSpec_t got, input decodePkg::regSpec_t exp,
		input string what);
		if (got.rdA !== exp.rdA || got.rdB !== exp.rdB || got.wrEn !== exp.wrEn
			|| (exp.wrEn && got.wr !== exp.wr))
			abortRun($sformatf("error %0d ns: %s spec is %h, expected %h", $time, what, got, exp));
	endtask

	task automatic compareBundle(input decodePkg::decoded_t got, input decodePkg::decoded_t exp,
		input string what);
		checkFmt(got.fmt, exp.fmt, what);
		checkCtrl(got.ctrl, exp.ctrl, what);
		checkSpec(got.spec, exp.spec, what);
		checkWord(got.opA, exp.opA, {what, " opA"});
		checkWord(got.opB, exp.opB, {what, " opB"});
		checkWord(got.imm, exp.imm, {what, " imm"});
		checkWord(got.incrPc, exp.incrPc, {what, " incrPc"});
	endtask

	// Flags are memRead, memWrite, isBranch, isJump, linkWrite from the left
	task automatic addRow(input logic [15:0] word, input logic wbEn, input logic [2:0] wbAddr,
		input logic [15:0] wbData, input int hold, input decodePkg::format_e fmt,
		input decodePkg::aluOp_e aluOp, input logic [4:0] flags, input logic [2:0] rdA,
		input logic [2:0] rdB, input logic [2:0] wr, input logic wrEn, input logic [15:0] imm);
		row_t r;
		r.instr = word;
		r.incrPc = 16'h0102 + 16'(2 * rows.size());
		r.wb = '{en: wbEn, addr: wbAddr, data: wbData};
		r.hold = 4'(hold);
		r.fmt = fmt;
		r.ctrl = '{aluOp: aluOp, memRead: flags[4], memWrite: flags[3], isBranch: flags[2],
			isJump: flags[1], linkWrite: flags[0]};
		r.spec = '{rdA: rdA, rdB: rdB, wr: wr, wrEn: wrEn};
		r.imm = imm;
		rows.push_back(r);
	endtask

	task automatic buildTable();
		// Right after reset every operand reads zero
		addRow(16'h0800, 0, 0, 0, 1, decodePkg::formJ, decodePkg::opPass, 5'b0, 0, 0, 0, 0, 0);
		addRow({decodePkg::ADDI, 3'd1, 3'd2, 5'h1f}, 1, 1, 16'h1111, 0, decodePkg::formI1,
			decodePkg::opAdd, 5'b0, 1, 0, 2, 1, 16'hffff);
		addRow({decodePkg::SUBI, 3'd2, 3'd3, 5'h05}, 1, 2, 16'h2222, 2, decodePkg::formI1,
			decodePkg::opSub, 5'b0, 2, 0, 3, 1, 16'h0005);
		addRow({decodePkg::XORI, 3'd3, 3'd4, 5'h1a}, 1, 3, 16'h3333, 0, decodePkg::formI1,
			decodePkg::opXor, 5'b0, 3, 0, 4, 1, 16'h001a);
		addRow({decodePkg::ANDNI, 3'd4, 3'd5, 5'h0f}, 1, 4, 16'h4444, 3, decodePkg::formI1,
			decodePkg::opAndn, 5'b0, 4, 0, 5, 1, 16'h000f);
		addRow({decodePkg::ST, 3'd5, 3'd6, 5'h10}, 1, 5, 16'h5555, 0, decodePkg::formI1,
			decodePkg::opAdd, 5'b01000, 5, 6, 0, 0, 16'hfff0);
		addRow({decodePkg::LD, 3'd6, 3'd0, 5'h03}, 1, 6, 16'h6666, 1, decodePkg::formI1,
			decodePkg::opAdd, 5'b10000, 6, 0, 0, 1, 16'h0003);
		addRow({decodePkg::STU, 3'd7, 3'd1, 5'h01}, 1, 7, 16'h7777, 0, decodePkg::formI1,
			decodePkg::opAdd, 5'b01000, 7, 1, 7, 1, 16'h0001);
		addRow({decodePkg::LBI, 3'd0, 8'h80}, 1, 0, 16'h0abc, 2, decodePkg::formI2,
			decodePkg::opPass, 5'b0, 0, 0, 0, 1, 16'hff80);
		addRow({decodePkg::SLBI, 3'd1, 8'h9c}, 0, 0, 0, 0, decodePkg::formI2,
			decodePkg::opShiftLoad, 5'b0, 1, 0, 1, 1, 16'h009c);
		addRow({decodePkg::BEQZ, 3'd2, 8'h7f}, 0, 0, 0, 1, decodePkg::formI2,
			decodePkg::opPass, 5'b00100, 2, 0, 0, 0, 16'h007f);
		addRow({decodePkg::BNEZ, 3'd3, 8'hfe}, 0, 0, 0, 0, decodePkg::formI2,
			decodePkg::opPass, 5'b00100, 3, 0, 0, 0, 16'hfffe);
		addRow({decodePkg::JR, 3'd4, 8'h04}, 0, 0, 0, 3, decodePkg::formI2,
			decodePkg::opAdd, 5'b00010, 4, 0, 0, 0, 16'h0004);
		addRow({decodePkg::JALR, 3'd5, 8'hf0}, 1, 5, 16'h5a5a, 0, decodePkg::formI2,
			decodePkg::opAdd, 5'b00011, 5, 0, 7, 1, 16'hfff0);
		addRow({decodePkg::J, 11'h3ff}, 0, 0, 0, 0, decodePkg::formJ,
			decodePkg::opAdd, 5'b00010, 0, 0, 0, 0, 16'h03ff);
		addRow({decodePkg::JAL, 11'h400}, 0, 0, 0, 2, decodePkg::formJ,
			decodePkg::opAdd, 5'b00011, 0, 0, 7, 1, 16'hfc00);
		addRow({decodePkg::ALU, 3'd1, 3'd2, 3'd3, 2'b00}, 0, 0, 0, 0, decodePkg::formR,
			decodePkg::opAdd, 5'b0, 1, 2, 3, 1, 16'h0000);
		addRow({decodePkg::ALU, 3'd6, 3'd7, 3'd0, 2'b01}, 1, 7, 16'h0f0f, 1, decodePkg::formR,
			decodePkg::opSub, 5'b0, 6, 7, 0, 1, 16'h0000);
		addRow({decodePkg::ALU, 3'd3, 3'd4, 3'd5, 2'b10}, 0, 0, 0, 0, decodePkg::formR,
			decodePkg::opXor, 5'b0, 3, 4, 5, 1, 16'h0000);
		addRow({decodePkg::ALU, 3'd5, 3'd0, 3'd1, 2'b11}, 0, 0, 0, 0, decodePkg::formR,
			decodePkg::opAndn, 5'b0, 5, 0, 1, 1, 16'h0000);
		addRow(16'hf800, 0, 0, 0, 0, decodePkg::formJ, decodePkg::opPass, 5'b0, 0, 0, 0, 0, 0);
	endtask

	// Expected bundle at acceptance including forwarding from the writeback of the same cycle
	function automatic decodePkg::decoded_t expectedBundle(input row_t r);
		decodePkg::decoded_t e;
		e.ctrl = r.ctrl;
		e.spec = r.spec;
		e.opA = (r.wb.en && r.wb.addr == r.spec.rdA) ? r.wb.data : shadow[r.spec.rdA];
		e.opB = (r.wb.en && r.wb.addr == r.spec.rdB) ? r.wb.data : shadow[r.spec.rdB];
		e.imm = r.imm;
		e.incrPc = r.incrPc;
		e.fmt = r.fmt;
		return e;
	endfunction

	initial begin
		int stallSum;
		int limit;
		logic acc;
		inValid = 1'b0;
		instr = '0;
		incrPc = '0;
		wb = '0;
		outReady = 1'b1;
		for (int i = 0; i < 8; i++) shadow[i] = '0;
		buildTable();

		// Worst case idle and random stall is three cycles each per row
		stallSum = 6 * rows.size();
		foreach (rows[i]) stallSum += int'(rows[i].hold);
		limit = 4 * (rows.size() + stallSum) + 10;
		fork
			begin
				repeat (limit) @(posedge clk);
				abortRun("Timeout, the DUT stopped moving instructions");
			end
		join_none

		@(posedge rstN);
		@(negedge clk);
		if (outValid !== 1'b0 || inReady !== 1'b1)
			abortRun("Outputs were not idle after reset");

		foreach (rows[i]) begin
			repeat (int'(takeBits(2))) begin
				@(posedge clk);
				inValid <= 1'b0;
				wb <= '0;
			end
			@(posedge clk);
			inValid <= 1'b1;
			instr <= rows[i].instr;
			incrPc <= rows[i].incrPc;
			wb <= rows[i].wb;
			do begin
				@(negedge clk);
				acc = inReady; // Sampled away from the edge
				@(posedge clk);
			end while (!acc);
			expQ.push_back(expectedBundle(rows[i]));
			holdQ.push_back(int'(rows[i].hold));
			if (rows[i].wb.en) shadow[rows[i].wb.addr] = rows[i].wb.data;
			inValid <= 1'b0;
			wb <= '0;
			@(negedge clk);
			if (outValid !== 1'b1)
				abortRun($sformatf("Row %0d did not show up one cycle after acceptance", i));
		end

		wait (checked == rows.size());
		@(negedge clk);
		if (outValid !== 1'b0) begin
			abortRun("Extra output left over after the last row");
		end else begin
			$display("** PASS **");
			$finish;
		end
	end

	// Back-pressure on the output is driven on the rising edge
	always @(posedge clk) begin
		if (holdLeft > 0) begin
			outReady <= 1'b0;
			holdLeft = holdLeft - 1;
		end else begin
			outReady <= 1'b1;
		end
	end

	// Output monitor where bundles must leave once each and in order
	always @(negedge clk) begin
		if (rstN && outValid) begin
			if (heldValid) compareBundle(outBundle, heldBundle, "stalled bundle");
			if (outReady) begin
				if (expQ.size() == 0)
					abortRun("Output valid with no instruction outstanding");
				compareBundle(outBundle, expQ.pop_front(), $sformatf("row %0d", checked));
				holdLeft = holdQ.pop_front();
				if (takeBits(1) == 32'd1) holdLeft += int'(takeBits(2));
				checked++;
				heldValid = 0;
			end else begin
				heldValid = 1;
				heldBundle = outBundle;
			end
		end else begin
			heldValid = 0;
		end
	end

endmodule
